// File: design/trapPkg.sv
package trapPkg;

    // Halfword PC, byte address without bit 0
    typedef logic [30:0] pc_t;
    typedef logic [2:0] fetchId_t;
    // Halfword offset inside an 8-halfword fetch block
    typedef logic [2:0] fetchOffs_t;
    typedef logic [7:0] bhist_t;
    typedef logic [5:0] sqN_t;
    typedef logic [3:0] cause_t;
    // Word address of the trap vector base
    typedef logic [29:0] vec_t;
    // One bit per cause
    typedef logic [15:0] deleg_t;

    typedef enum logic [3:0] {
        FLAGS_NONE,
        FLAGS_PRED_TAKEN,
        FLAGS_PRED_NOT_TAKEN,
        FLAGS_TRAP,
        FLAGS_FENCE,
        FLAGS_ORDERING,
        FLAGS_ILLEGAL_INSTR,
        FLAGS_ACCESS_FAULT,
        FLAGS_XRET
    } trapFlags_e;

    typedef enum logic [1:0] {
        PRIV_USER = 2'd0,
        PRIV_SUPERVISOR = 2'd1,
        PRIV_MACHINE = 2'd3
    } priv_e;

    // Trap names carried by FLAGS_TRAP micro-ops
    localparam cause_t TRAP_BREAK = 4'd3;
    localparam cause_t TRAP_ECALL_U = 4'd8;
    localparam cause_t TRAP_ECALL_S = 4'd9;
    localparam cause_t TRAP_ECALL_M = 4'd11;

    localparam cause_t CAUSE_ILLEGAL = 4'd2;
    localparam cause_t CAUSE_ACCESS = 4'd4;

    // Register index of the configuration write port
    typedef enum logic [2:0] {
        SEL_MTVEC,
        SEL_STVEC,
        SEL_MEDELEG,
        SEL_MIDELEG,
        SEL_PRIV
    } csrSel_e;

endpackage

// File: design/pcFile.sv
`timescale 1ns/1ns

module pcFile #(
    parameter int PC_ENTRIES = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic pcWriteEn,
    input  trapPkg::fetchId_t pcWriteId,
    input  trapPkg::pc_t pcWritePc,
    input  trapPkg::bhist_t pcWriteHist,
    input  trapPkg::fetchOffs_t pcWriteBranchPos,
    input  logic pcWriteBpiPredicted,
    input  logic pcWriteBpiTaken,
    input  logic pcWriteBpiIsJump,
    input  trapPkg::fetchId_t pcReadId,
    output trapPkg::pc_t rdPc,
    output trapPkg::bhist_t rdHist,
    output trapPkg::fetchOffs_t rdBranchPos,
    output logic rdBpiPredicted,
    output logic rdBpiTaken,
    output logic rdBpiIsJump
);

    trapPkg::pc_t pcs [PC_ENTRIES];
    trapPkg::bhist_t hists [PC_ENTRIES];
    trapPkg::fetchOffs_t branchPos [PC_ENTRIES];
    logic [PC_ENTRIES-1:0] predicted;
    logic [PC_ENTRIES-1:0] taken;
    logic [PC_ENTRIES-1:0] isJump;

    always_ff @(posedge clk) begin
        if (pcWriteEn) begin
            pcs[pcWriteId] <= pcWritePc;
            hists[pcWriteId] <= pcWriteHist;
            branchPos[pcWriteId] <= pcWriteBranchPos;
            taken[pcWriteId] <= pcWriteBpiTaken;
            isJump[pcWriteId] <= pcWriteBpiIsJump;
        end
    end

    // Entries never written since reset carry no prediction
    always_ff @(posedge clk) begin
        if (rst) begin
            predicted <= '0;
        end else if (pcWriteEn) begin
            predicted[pcWriteId] <= pcWriteBpiPredicted;
        end
    end

    assign rdPc = pcs[pcReadId];
    assign rdHist = hists[pcReadId];
    assign rdBranchPos = branchPos[pcReadId];
    assign rdBpiPredicted = predicted[pcReadId];
    assign rdBpiTaken = taken[pcReadId];
    assign rdBpiIsJump = isJump[pcReadId];

endmodule

// File: design/trapCsr.sv
`timescale 1ns/1ns

module trapCsr (
    input  logic clk,
    input  logic rst,
    input  logic csrWe,
    input  trapPkg::csrSel_e csrSel,
    input  logic [31:0] csrData,
    input  logic infoValid,
    input  trapPkg::pc_t infoPc,
    input  trapPkg::cause_t infoCause,
    input  logic infoDelegate,
    input  logic infoIsInterrupt,
    input  logic xretValid,
    output trapPkg::priv_e priv,
    output trapPkg::vec_t mtvec,
    output trapPkg::vec_t stvec,
    output trapPkg::deleg_t medeleg,
    output trapPkg::deleg_t mideleg,
    output trapPkg::pc_t retvec
);

    trapPkg::priv_e mpp;
    trapPkg::priv_e spp;
    trapPkg::pc_t mepc;
    trapPkg::pc_t sepc;

    always_ff @(posedge clk) begin
        if (rst) begin
            priv <= trapPkg::PRIV_MACHINE;
            mpp <= trapPkg::PRIV_MACHINE;
            spp <= trapPkg::PRIV_USER;
            mtvec <= '0;
            stvec <= '0;
            medeleg <= '0;
            mideleg <= '0;
        end else if (infoValid) begin
            if (infoDelegate) begin
                spp <= priv;
                priv <= trapPkg::PRIV_SUPERVISOR;
            end else begin
                mpp <= priv;
                priv <= trapPkg::PRIV_MACHINE;
            end
        end else if (xretValid) begin
            priv <= (priv == trapPkg::PRIV_MACHINE) ? mpp : spp;
        end else if (csrWe) begin
            case (csrSel)
                trapPkg::SEL_MTVEC: mtvec <= csrData[31:2];
                trapPkg::SEL_STVEC: stvec <= csrData[31:2];
                trapPkg::SEL_MEDELEG: medeleg <= csrData[15:0];
                trapPkg::SEL_MIDELEG: mideleg <= csrData[15:0];
                trapPkg::SEL_PRIV: priv <= trapPkg::priv_e'(csrData[1:0]);
                default: mtvec <= mtvec;
            endcase
        end
    end

    // Return PC of the level that took the trap
    always_ff @(posedge clk) begin
        if (infoValid) begin
            if (infoDelegate) begin
                sepc <= infoPc;
            end else begin
                mepc <= infoPc;
            end
        end
    end

    assign retvec = (priv == trapPkg::PRIV_MACHINE) ? mepc : sepc;

endmodule

// File: design/trapHandler.sv
`timescale 1ns/1ns

module trapHandler (
    input  logic clk,
    input  logic rst,
    input  logic trapValid,
    input  trapPkg::trapFlags_e trapFlags,
    input  logic [4:0] trapName,
    input  trapPkg::fetchId_t fetchId,
    input  trapPkg::fetchOffs_t fetchOffs,
    input  logic compressed,
    input  trapPkg::sqN_t sqN,
    input  trapPkg::pc_t rdPc,
    input  trapPkg::bhist_t rdHist,
    input  trapPkg::fetchOffs_t rdBranchPos,
    input  logic rdBpiPredicted,
    input  logic rdBpiTaken,
    input  logic rdBpiIsJump,
    input  trapPkg::priv_e priv,
    input  trapPkg::vec_t mtvec,
    input  trapPkg::vec_t stvec,
    input  trapPkg::deleg_t medeleg,
    input  trapPkg::deleg_t mideleg,
    input  trapPkg::pc_t retvec,
    input  logic irq,
    input  logic memBusy,
    input  logic allowBreak,
    output trapPkg::fetchId_t pcReadId,
    output logic branchTaken,
    output trapPkg::pc_t branchDstPc,
    output trapPkg::sqN_t branchSqN,
    output trapPkg::fetchId_t branchFetchId,
    output trapPkg::bhist_t branchHistory,
    output logic infoValid,
    output trapPkg::pc_t infoPc,
    output trapPkg::cause_t infoCause,
    output logic infoDelegate,
    output logic infoIsInterrupt,
    output logic xretValid,
    output logic bpValid,
    output trapPkg::pc_t bpPc,
    output logic bpCompressed,
    output trapPkg::bhist_t bpHistory,
    output logic bpPredicted,
    output logic bpTaken,
    output logic bpIsJump,
    output logic bpBranchTaken,
    output logic fence,
    output logic clearICache,
    output logic disableIFetch,
    output logic halt
);

    logic memoryWait;
    logic instrFence;
    logic irqPending;
    trapPkg::pc_t instrPc;
    trapPkg::pc_t nextPc;
    trapPkg::pc_t dstPc;
    trapPkg::bhist_t instrHist;
    trapPkg::cause_t cause;
    logic delegate;
    logic isHalt;
    logic isSerial;
    logic isXret;
    logic isTrap;
    logic isRedirect;

    assign pcReadId = fetchId;
    assign disableIFetch = memoryWait;

    // The offset names the last halfword of the instruction
    assign instrPc = {rdPc[30:3], fetchOffs} - (compressed ? 31'd0 : 31'd1);
    assign nextPc = instrPc + (compressed ? 31'd1 : 31'd2);

    // Pending interrupt overrides whatever the micro-op is
    assign isHalt = !irqPending && allowBreak && trapFlags == trapPkg::FLAGS_TRAP
        && trapName == {1'b0, trapPkg::TRAP_BREAK};
    assign isSerial = isHalt || (!irqPending && (trapFlags == trapPkg::FLAGS_FENCE
        || trapFlags == trapPkg::FLAGS_ORDERING));
    assign isXret = !irqPending && trapFlags == trapPkg::FLAGS_XRET;
    assign isTrap = irqPending || (!isHalt && (trapFlags == trapPkg::FLAGS_TRAP
        || trapFlags == trapPkg::FLAGS_ILLEGAL_INSTR
        || trapFlags == trapPkg::FLAGS_ACCESS_FAULT));
    assign isRedirect = isSerial || isXret || isTrap;

    always_comb begin
        instrHist = rdHist;
        // Conditional branch earlier in the block already shifted the history
        if (rdBpiPredicted && !rdBpiIsJump && fetchOffs > rdBranchPos) begin
            instrHist = {rdHist[$bits(trapPkg::bhist_t)-2:0], rdBpiTaken};
        end
    end

    always_comb begin
        case (trapFlags)
            trapPkg::FLAGS_TRAP: cause = trapName[3:0];
            trapPkg::FLAGS_ACCESS_FAULT: cause = trapPkg::CAUSE_ACCESS;
            default: cause = trapPkg::CAUSE_ILLEGAL;
        endcase
        // ecall comes in with the machine code
        if (cause == trapPkg::TRAP_ECALL_M && priv == trapPkg::PRIV_SUPERVISOR) begin
            cause = trapPkg::TRAP_ECALL_S;
        end else if (cause == trapPkg::TRAP_ECALL_M && priv == trapPkg::PRIV_USER) begin
            cause = trapPkg::TRAP_ECALL_U;
        end
        if (irqPending) begin
            cause = '0;
        end
        delegate = priv != trapPkg::PRIV_MACHINE
            && (irqPending ? mideleg[cause] : medeleg[cause]);

        if (isXret) begin
            dstPc = retvec;
        end else if (isTrap) begin
            dstPc = {delegate ? stvec : mtvec, 1'b0};
        end else begin
            dstPc = nextPc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            branchTaken <= 1'b0;
            infoValid <= 1'b0;
            xretValid <= 1'b0;
            bpValid <= 1'b0;
            halt <= 1'b0;
            fence <= 1'b0;
            clearICache <= 1'b0;
            memoryWait <= 1'b0;
            instrFence <= 1'b0;
            irqPending <= 1'b0;
        end else begin
            branchTaken <= trapValid && isRedirect;
            infoValid <= trapValid && isTrap;
            xretValid <= trapValid && isXret;
            bpValid <= trapValid && !isRedirect;
            halt <= trapValid && isHalt;
            fence <= trapValid && isSerial && trapFlags == trapPkg::FLAGS_FENCE;
            clearICache <= 1'b0;
            irqPending <= irqPending || irq;

            // A fence first clears the icache, then releases fetch
            if (memoryWait && !memBusy) begin
                if (instrFence) begin
                    instrFence <= 1'b0;
                    clearICache <= 1'b1;
                end else begin
                    memoryWait <= 1'b0;
                end
            end

            if (trapValid && isSerial && !isHalt) begin
                memoryWait <= 1'b1;
                if (trapFlags == trapPkg::FLAGS_FENCE) begin
                    instrFence <= 1'b1;
                end
            end

            if (trapValid && irqPending) begin
                irqPending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (trapValid) begin
            branchDstPc <= dstPc;
            branchSqN <= sqN;
            branchFetchId <= fetchId;
            branchHistory <= instrHist;
            infoPc <= instrPc;
            infoCause <= cause;
            infoDelegate <= delegate;
            infoIsInterrupt <= irqPending;
            bpPc <= rdPc;
            bpCompressed <= compressed;
            bpHistory <= rdHist;
            bpPredicted <= rdBpiPredicted;
            bpTaken <= rdBpiTaken;
            bpIsJump <= rdBpiIsJump;
            bpBranchTaken <= trapFlags == trapPkg::FLAGS_PRED_TAKEN;
        end
    end

endmodule

// File: design/trapUnit.sv
`timescale 1ns/1ns

module trapUnit #(
    parameter int PC_ENTRIES = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic pcWriteEn,
    input  trapPkg::fetchId_t pcWriteId,
    input  trapPkg::pc_t pcWritePc,
    input  trapPkg::bhist_t pcWriteHist,
    input  trapPkg::fetchOffs_t pcWriteBranchPos,
    input  logic pcWriteBpiPredicted,
    input  logic pcWriteBpiTaken,
    input  logic pcWriteBpiIsJump,
    input  logic trapValid,
    input  trapPkg::trapFlags_e trapFlags,
    input  logic [4:0] trapName,
    input  trapPkg::fetchId_t fetchId,
    input  trapPkg::fetchOffs_t fetchOffs,
    input  logic compressed,
    input  trapPkg::sqN_t sqN,
    input  logic irq,
    input  logic memBusy,
    input  logic allowBreak,
    input  logic csrWe,
    input  trapPkg::csrSel_e csrSel,
    input  logic [31:0] csrData,
    output logic branchTaken,
    output trapPkg::pc_t branchDstPc,
    output trapPkg::sqN_t branchSqN,
    output trapPkg::fetchId_t branchFetchId,
    output trapPkg::bhist_t branchHistory,
    output logic bpValid,
    output trapPkg::pc_t bpPc,
    output logic bpCompressed,
    output trapPkg::bhist_t bpHistory,
    output logic bpPredicted,
    output logic bpTaken,
    output logic bpIsJump,
    output logic bpBranchTaken,
    output logic fence,
    output logic clearICache,
    output logic disableIFetch,
    output logic halt
);

    trapPkg::fetchId_t pcReadId;
    trapPkg::pc_t rdPc;
    trapPkg::bhist_t rdHist;
    trapPkg::fetchOffs_t rdBranchPos;
    logic rdBpiPredicted;
    logic rdBpiTaken;
    logic rdBpiIsJump;

    trapPkg::priv_e priv;
    trapPkg::vec_t mtvec;
    trapPkg::vec_t stvec;
    trapPkg::deleg_t medeleg;
    trapPkg::deleg_t mideleg;
    trapPkg::pc_t retvec;

    logic infoValid;
    trapPkg::pc_t infoPc;
    trapPkg::cause_t infoCause;
    logic infoDelegate;
    logic infoIsInterrupt;
    logic xretValid;

    pcFile #(
        .PC_ENTRIES(PC_ENTRIES)
    ) pcFile_inst (.*);

    trapHandler trapHandler_inst (.*);

    trapCsr trapCsr_inst (.*);

endmodule

// File: verification/trapUnitChk.sv
`timescale 1ns/1ns

module trapUnitChk (
    input logic clk,
    input logic rst,
    input logic halt,
    input logic fence,
    input logic clearICache,
    input logic disableIFetch,
    input logic branchTaken,
    input logic bpValid
);

    // Control pulses last one cycle
    haltPulse: assert property (@(posedge clk) disable iff (rst) halt |=> !halt)
        else $error("halt stayed high for more than one cycle");
    fencePulse: assert property (@(posedge clk) disable iff (rst) fence |=> !fence)
        else $error("fence stayed high for more than one cycle");
    clearPulse: assert property (@(posedge clk) disable iff (rst) clearICache |=> !clearICache)
        else $error("clearICache stayed high for more than one cycle");

    clearInWait: assert property (@(posedge clk) disable iff (rst) clearICache |-> disableIFetch)
        else $error("clearICache pulsed while fetch was enabled");

    // A micro-op either redirects or updates the predictor
    oneResult: assert property (@(posedge clk) disable iff (rst) !(branchTaken && bpValid))
        else $error("branchTaken and bpValid high in the same cycle");

endmodule

bind trapHandler trapUnitChk trapUnitChk_inst (
    .clk(clk),
    .rst(rst),
    .halt(halt),
    .fence(fence),
    .clearICache(clearICache),
    .disableIFetch(disableIFetch),
    .branchTaken(branchTaken),
    .bpValid(bpValid)
);

// File: verification/trapUnitTb.sv
`timescale 1ns/1ns

module trapUnitTb;

    logic clk;
    logic rst;
    logic pcWriteEn;
    trapPkg::fetchId_t pcWriteId;
    trapPkg::pc_t pcWritePc;
    trapPkg::bhist_t pcWriteHist;
    trapPkg::fetchOffs_t pcWriteBranchPos;
    logic pcWriteBpiPredicted;
    logic pcWriteBpiTaken;
    logic pcWriteBpiIsJump;
    logic trapValid;
    trapPkg::trapFlags_e trapFlags;
    logic [4:0] trapName;
    trapPkg::fetchId_t fetchId;
    trapPkg::fetchOffs_t fetchOffs;
    logic compressed;
    trapPkg::sqN_t sqN;
    logic irq;
    logic memBusy;
    logic allowBreak;
    logic csrWe;
    trapPkg::csrSel_e csrSel;
    logic [31:0] csrData;
    logic branchTaken;
    trapPkg::pc_t branchDstPc;
    trapPkg::sqN_t branchSqN;
    trapPkg::fetchId_t branchFetchId;
    trapPkg::bhist_t branchHistory;
    logic bpValid;
    trapPkg::pc_t bpPc;
    logic bpCompressed;
    trapPkg::bhist_t bpHistory;
    logic bpPredicted;
    logic bpTaken;
    logic bpIsJump;
    logic bpBranchTaken;
    logic fence;
    logic clearICache;
    logic disableIFetch;
    logic halt;

    // Reference model
    trapPkg::pc_t mPc [8];
    trapPkg::bhist_t mHist [8];
    trapPkg::fetchOffs_t mPos [8];
    logic mPred [8];
    logic mTaken [8];
    logic mJump [8];
    trapPkg::priv_e mPriv;
    trapPkg::priv_e mMpp;
    trapPkg::priv_e mSpp;
    trapPkg::vec_t mMtvec;
    trapPkg::vec_t mStvec;
    trapPkg::deleg_t mMedeleg;
    trapPkg::deleg_t mMideleg;
    trapPkg::pc_t mMepc;
    trapPkg::pc_t mSepc;
    logic mepcKnown;
    logic sepcKnown;
    logic irqPend;

    string testName;
    int testChecks;
    int testErrors;
    int totalChecks;
    int totalErrors;

    trapUnit #(
        .PC_ENTRIES(8)
    ) trapUnit_inst (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic step();
        @(posedge clk);
        #5;
    endtask

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        testChecks++;
        assert (act === exp) else begin
            $display("Mismatch in %s, %s: expected %h, actual %h", testName, what, exp, act);
            testErrors++;
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("Timeout in %s: %s did not happen within 50 cycles", testName, what);
        testErrors++;
    endtask

    task automatic beginTest(input string name);
        testName = name;
        testChecks = 0;
        testErrors = 0;
    endtask

    task automatic endTest();
        $display("%s: %0d checks, %0d errors", testName, testChecks, testErrors);
        totalChecks += testChecks;
        totalErrors += testErrors;
    endtask

    task automatic writeEntry(input trapPkg::fetchId_t id, input logic pred, input logic jump,
                              input trapPkg::fetchOffs_t pos);
        pcWriteEn = 1'b1;
        pcWriteId = id;
        pcWritePc = 31'($urandom);
        pcWriteHist = 8'($urandom);
        pcWriteBranchPos = pos;
        pcWriteBpiPredicted = pred;
        pcWriteBpiTaken = 1'($urandom);
        pcWriteBpiIsJump = jump;
        mPc[id] = pcWritePc;
        mHist[id] = pcWriteHist;
        mPos[id] = pos;
        mPred[id] = pred;
        mTaken[id] = pcWriteBpiTaken;
        mJump[id] = jump;
        step();
        pcWriteEn = 1'b0;
    endtask

    // Priv writes stay on the three legal levels
    function automatic logic [31:0] csrValue(input trapPkg::csrSel_e sel);
        int p;
        p = $urandom % 3;
        if (sel == trapPkg::SEL_PRIV) begin
            return (p == 2) ? 32'd3 : 32'(p);
        end
        return $urandom;
    endfunction

    function automatic void applyCsr(input trapPkg::csrSel_e sel, input logic [31:0] data);
        case (sel)
            trapPkg::SEL_MTVEC: mMtvec = data[31:2];
            trapPkg::SEL_STVEC: mStvec = data[31:2];
            trapPkg::SEL_MEDELEG: mMedeleg = data[15:0];
            trapPkg::SEL_MIDELEG: mMideleg = data[15:0];
            default: mPriv = trapPkg::priv_e'(data[1:0]);
        endcase
    endfunction

    task automatic csrWrite(input trapPkg::csrSel_e sel, input logic [31:0] data);
        csrWe = 1'b1;
        csrSel = sel;
        csrData = data;
        applyCsr(sel, data);
        step();
        csrWe = 1'b0;
    endtask

    task automatic randomizeCsrs();
        for (int s = 0; s < 5; s++) begin
            csrWrite(trapPkg::csrSel_e'(s), csrValue(trapPkg::csrSel_e'(s)));
        end
    endtask

    task automatic pulseIrq();
        irq = 1'b1;
        step();
        irq = 1'b0;
        irqPend = 1'b1;
    endtask

    task automatic runOp(input trapPkg::trapFlags_e flags, input logic [4:0] name,
                         input logic allow, input trapPkg::fetchId_t id,
                         input trapPkg::fetchOffs_t offs);
        trapPkg::pc_t instrPc;
        trapPkg::pc_t nextPc;
        trapPkg::pc_t dst;
        trapPkg::bhist_t hist;
        trapPkg::cause_t cause;
        trapPkg::sqN_t sq;
        trapPkg::csrSel_e sel;
        logic [31:0] data;
        logic comp;
        logic dlg;
        logic isHalt;
        logic isSerial;
        logic isXret;
        logic isTrap;
        logic redirect;
        logic doCsr;
        int busy;
        int n;

        comp = 1'($urandom);
        sq = 6'($urandom);
        busy = $urandom % 4;
        instrPc = {mPc[id][30:3], offs} - (comp ? 31'd0 : 31'd1);
        nextPc = instrPc + (comp ? 31'd1 : 31'd2);
        hist = mHist[id];
        if (mPred[id] && !mJump[id] && offs > mPos[id]) begin
            hist = {hist[6:0], mTaken[id]};
        end

        case (flags)
            trapPkg::FLAGS_TRAP: cause = name[3:0];
            trapPkg::FLAGS_ACCESS_FAULT: cause = trapPkg::CAUSE_ACCESS;
            default: cause = trapPkg::CAUSE_ILLEGAL;
        endcase
        if (cause == trapPkg::TRAP_ECALL_M && mPriv == trapPkg::PRIV_SUPERVISOR) begin
            cause = trapPkg::TRAP_ECALL_S;
        end else if (cause == trapPkg::TRAP_ECALL_M && mPriv == trapPkg::PRIV_USER) begin
            cause = trapPkg::TRAP_ECALL_U;
        end
        if (irqPend) begin
            cause = 4'd0;
        end
        dlg = mPriv != trapPkg::PRIV_MACHINE && (irqPend ? mMideleg[cause] : mMedeleg[cause]);
        isHalt = !irqPend && allow && flags == trapPkg::FLAGS_TRAP && name == 5'd3;
        isSerial = isHalt || (!irqPend && (flags == trapPkg::FLAGS_FENCE
            || flags == trapPkg::FLAGS_ORDERING));
        isXret = !irqPend && flags == trapPkg::FLAGS_XRET;
        isTrap = irqPend || (!isHalt && (flags == trapPkg::FLAGS_TRAP
            || flags == trapPkg::FLAGS_ILLEGAL_INSTR || flags == trapPkg::FLAGS_ACCESS_FAULT));
        redirect = isSerial || isXret || isTrap;
        if (isXret) begin
            dst = (mPriv == trapPkg::PRIV_MACHINE) ? mMepc : mSepc;
        end else if (isTrap) begin
            dst = {(dlg ? mStvec : mMtvec), 1'b0};
        end else begin
            dst = nextPc;
        end

        trapValid = 1'b1;
        trapFlags = flags;
        trapName = name;
        fetchId = id;
        fetchOffs = offs;
        compressed = comp;
        sqN = sq;
        allowBreak = allow;
        memBusy = busy > 0;
        step();
        trapValid = 1'b0;

        check("branchTaken", redirect, branchTaken);
        if (redirect) begin
            check("branchDstPc", dst, branchDstPc);
            check("branchSqN", sq, branchSqN);
            check("branchFetchId", id, branchFetchId);
            check("branchHistory", hist, branchHistory);
        end
        check("bpValid", !redirect, bpValid);
        if (!redirect) begin
            check("bpPc", mPc[id], bpPc);
            check("bpCompressed", comp, bpCompressed);
            check("bpHistory", mHist[id], bpHistory);
            check("bpPredicted", mPred[id], bpPredicted);
            check("bpTaken", mTaken[id], bpTaken);
            check("bpIsJump", mJump[id], bpIsJump);
            check("bpBranchTaken", flags == trapPkg::FLAGS_PRED_TAKEN, bpBranchTaken);
        end
        check("halt", isHalt, halt);
        check("fence", isSerial && flags == trapPkg::FLAGS_FENCE, fence);
        check("disableIFetch", isSerial && !isHalt, disableIFetch);

        // Configuration write lands on the same edge as the register update
        doCsr = 1'($urandom);
        sel = trapPkg::csrSel_e'($urandom % 5);
        data = csrValue(sel);
        csrWe = doCsr;
        csrSel = sel;
        csrData = data;
        step();
        csrWe = 1'b0;
        if (isTrap && dlg) begin
            mSpp = mPriv;
            mPriv = trapPkg::PRIV_SUPERVISOR;
            mSepc = instrPc;
            sepcKnown = 1'b1;
        end else if (isTrap) begin
            mMpp = mPriv;
            mPriv = trapPkg::PRIV_MACHINE;
            mMepc = instrPc;
            mepcKnown = 1'b1;
        end else if (isXret) begin
            mPriv = (mPriv == trapPkg::PRIV_MACHINE) ? mMpp : mSpp;
        end else if (doCsr) begin
            applyCsr(sel, data);
        end
        irqPend = 1'b0;

        if (isSerial && !isHalt) begin
            for (int i = 0; i < busy; i++) begin
                check("disableIFetch while memBusy", 1, disableIFetch);
                if (i + 1 < busy) begin
                    step();
                end
            end
            memBusy = 1'b0;
            if (flags == trapPkg::FLAGS_FENCE) begin
                n = 0;
                while (clearICache !== 1'b1 && n < 50) begin
                    step();
                    n++;
                end
                if (clearICache !== 1'b1) begin
                    reportTimeout("clearICache");
                end else begin
                    check("disableIFetch at clearICache", 1, disableIFetch);
                end
            end
            n = 0;
            while (disableIFetch !== 1'b0 && n < 50) begin
                step();
                n++;
                check("clearICache", 0, clearICache);
            end
            if (disableIFetch !== 1'b0) begin
                reportTimeout("release of disableIFetch");
            end
        end
        memBusy = 1'b0;
    endtask

    initial begin
        trapPkg::trapFlags_e flags;
        trapPkg::fetchId_t id;
        trapPkg::csrSel_e sel;
        int k;

        void'($urandom(32'h98d3));
        rst = 1'b1;
        pcWriteEn = 1'b0;
        pcWriteId = '0;
        pcWritePc = '0;
        pcWriteHist = '0;
        pcWriteBranchPos = '0;
        pcWriteBpiPredicted = 1'b0;
        pcWriteBpiTaken = 1'b0;
        pcWriteBpiIsJump = 1'b0;
        trapValid = 1'b0;
        trapFlags = trapPkg::FLAGS_NONE;
        trapName = '0;
        fetchId = '0;
        fetchOffs = '0;
        compressed = 1'b0;
        sqN = '0;
        irq = 1'b0;
        memBusy = 1'b0;
        allowBreak = 1'b0;
        csrWe = 1'b0;
        csrSel = trapPkg::SEL_MTVEC;
        csrData = '0;
        mPriv = trapPkg::PRIV_MACHINE;
        mMpp = trapPkg::PRIV_MACHINE;
        mSpp = trapPkg::PRIV_USER;
        mMtvec = '0;
        mStvec = '0;
        mMedeleg = '0;
        mMideleg = '0;
        mepcKnown = 1'b0;
        sepcKnown = 1'b0;
        irqPend = 1'b0;
        totalChecks = 0;
        totalErrors = 0;
        repeat (3) @(posedge clk);
        #5;
        rst = 1'b0;

        for (int i = 0; i < 8; i++) begin
            writeEntry(3'(i), 1'($urandom), 1'($urandom), 3'($urandom));
        end

        beginTest("branch");
        repeat (20) begin
            flags = trapPkg::trapFlags_e'($urandom % 3);
            runOp(flags, 5'($urandom), 1'($urandom), 3'($urandom), 3'($urandom));
        end
        endTest();

        beginTest("trap");
        repeat (30) begin
            randomizeCsrs();
            k = $urandom % 3;
            flags = (k == 2) ? trapPkg::FLAGS_TRAP : trapPkg::trapFlags_e'(6 + k);
            runOp(flags, 1'($urandom) ? 5'd11 : 5'($urandom), 1'b0, 3'($urandom),
                  3'($urandom));
            // The xret shows the level and return PC that the trap left behind
            runOp(trapPkg::FLAGS_XRET, 5'($urandom), 1'b0, 3'($urandom), 3'($urandom));
        end
        endTest();

        beginTest("xret");
        repeat (20) begin
            randomizeCsrs();
            runOp(trapPkg::FLAGS_ILLEGAL_INSTR, 5'd0, 1'b0, 3'($urandom), 3'($urandom));
            runOp(trapPkg::FLAGS_XRET, 5'($urandom), 1'b0, 3'($urandom), 3'($urandom));
            // ecall cause and delegation follow the restored level
            runOp(trapPkg::FLAGS_TRAP, 5'd11, 1'b0, 3'($urandom), 3'($urandom));
        end
        endTest();

        beginTest("fence");
        repeat (20) begin
            flags = 1'($urandom) ? trapPkg::FLAGS_FENCE : trapPkg::FLAGS_ORDERING;
            runOp(flags, 5'($urandom), 1'($urandom), 3'($urandom), 3'($urandom));
        end
        endTest();

        // Conditional prediction at slot 0, so any later offset extends the history
        beginTest("break");
        repeat (20) begin
            randomizeCsrs();
            id = 3'($urandom);
            writeEntry(id, 1'b1, 1'b0, 3'd0);
            runOp(trapPkg::FLAGS_TRAP, 5'd3, 1'($urandom), id, 3'($urandom % 7 + 1));
        end
        endTest();

        beginTest("irq");
        repeat (20) begin
            randomizeCsrs();
            pulseIrq();
            flags = trapPkg::trapFlags_e'($urandom % 9);
            runOp(flags, 5'($urandom), 1'($urandom), 3'($urandom), 3'($urandom));
            flags = trapPkg::trapFlags_e'($urandom % 8);
            runOp(flags, 5'($urandom), 1'($urandom), 3'($urandom), 3'($urandom));
        end
        endTest();

        beginTest("random");
        repeat (40) begin
            if ($urandom % 8 == 0) begin
                pulseIrq();
            end
            if ($urandom % 4 == 0) begin
                sel = trapPkg::csrSel_e'($urandom % 5);
                csrWrite(sel, csrValue(sel));
            end
            flags = trapPkg::trapFlags_e'($urandom % 9);
            // Return PC of the current level may not be written yet
            if (flags == trapPkg::FLAGS_XRET && !irqPend
                    && !((mPriv == trapPkg::PRIV_MACHINE) ? mepcKnown : sepcKnown)) begin
                flags = trapPkg::FLAGS_NONE;
            end
            runOp(flags, 5'($urandom), 1'($urandom), 3'($urandom), 3'($urandom));
        end
        endTest();

        $display("Total: %0d checks, %0d errors", totalChecks, totalErrors);
        if (totalErrors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
design/trapPkg.sv
design/pcFile.sv
design/trapCsr.sv
design/trapHandler.sv
design/trapUnit.sv
verification/trapUnitChk.sv
verification/trapUnitTb.sv

// File: Bender.yml
package:
  name: trap_unit

sources:
  - files:
      - design/trapPkg.sv
      - design/pcFile.sv
      - design/trapCsr.sv
      - design/trapHandler.sv
      - design/trapUnit.sv
  - target: test
    files:
      - verification/trapUnitChk.sv
      - verification/trapUnitTb.sv
